//--- include/sbox_cfg.svh
`ifndef SBOX_CFG_SVH
`define SBOX_CFG_SVH

// one S-box word as an element of GF(2^6)
`define SBOX_WORD_W 6

// words processed in parallel per block
`define SBOX_LANES 4

// round count field where 0 runs a single round
`define SBOX_ROUND_W 4

`endif

//--- source/sbox_ctrl_pkg.sv
`default_nettype none

`include "sbox_cfg.svh"

package sbox_ctrl_pkg;

  // operation selected at start
  typedef enum logic [1:0] {
    OP_SBOX  = 2'b00,
    OP_POWER = 2'b01
  } sbox_op_e;

  // round sequencer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_RUN  = 2'b01,
    ST_DONE = 2'b10
  } ctrl_state_e;

  typedef logic [`SBOX_WORD_W-1:0] word_t;

  // lane i works on word i
  typedef word_t [`SBOX_LANES-1:0] block_t;

endpackage

`default_nettype wire

//--- source/gf_tower_pkg.sv
`default_nettype none

package gf_tower_pkg;

  // GF(4) element in the tower basis with bit 1 as the high coefficient
  typedef logic [1:0] gf4_t;

  function automatic gf4_t gf4_square(gf4_t a);
    gf4_t c;
    c[0] = a[0] ^ a[1];
    c[1] = a[1];
    return c;
  endfunction

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    gf4_t c;
    logic t;
    t = a[1] & b[1];
    c[0] = (a[0] & b[0]) ^ t;
    c[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ t;
    return c;
  endfunction

  // a^3 is 1 for every nonzero a, so the product reduces to a mask on b
  function automatic gf4_t gf4_scale(gf4_t a, gf4_t b);
    logic t;
    t = a[0] | a[1];
    return t ? b : 2'b00;
  endfunction

endpackage

`default_nettype wire

//--- source/tower_power52.sv
`timescale 1ns/1ns
`default_nettype none

module tower_power52
  import sbox_ctrl_pkg::*;
  import gf_tower_pkg::*;
(
  input  logic  clk,
  input  word_t z,
  output word_t w
);

  gf4_t x0;
  gf4_t x1;
  gf4_t x2;
  gf4_t q0;
  gf4_t q1;
  gf4_t q2;
  // scaled cross terms where s_ij is scale(x_i, x_j)
  gf4_t s01;
  gf4_t s02;
  gf4_t s10;
  gf4_t s12;
  gf4_t s20;
  gf4_t s21;
  gf4_t m01;
  gf4_t m02;
  gf4_t m12;
  gf4_t c0;
  gf4_t c1;
  gf4_t c2;
  gf4_t r0;
  gf4_t r1;
  gf4_t r2;

  assign x0 = z[1:0];
  assign x1 = z[3:2];
  assign x2 = z[5:4];

  assign q0 = gf4_square(x0);
  assign q1 = gf4_square(x1);
  assign q2 = gf4_square(x2);

  assign s01 = gf4_scale(x0, x1);
  assign s02 = gf4_scale(x0, x2);
  assign s10 = gf4_scale(x1, x0);
  assign s12 = gf4_scale(x1, x2);
  assign s20 = gf4_scale(x2, x0);
  assign s21 = gf4_scale(x2, x1);

  // products of squares
  assign m01 = gf4_mul(q0, q1);
  assign m02 = gf4_mul(q0, q2);
  assign m12 = gf4_mul(q1, q2);

  // each square times the product of the other two coordinates
  assign c0 = gf4_mul(q0, gf4_mul(x1, x2));
  assign c1 = gf4_mul(q1, gf4_mul(x0, x2));
  assign c2 = gf4_mul(q2, gf4_mul(x0, x1));

  assign r0 = gf4_add(gf4_add(gf4_add(x0, x1), gf4_add(s10, s12)),
                      gf4_add(gf4_add(s20, m01), gf4_add(gf4_add(m02, c0), c2)));

  assign r1 = gf4_add(gf4_add(gf4_add(x1, x2), gf4_add(s01, s20)),
                      gf4_add(gf4_add(s21, m01), gf4_add(gf4_add(m12, c0), c1)));

  assign r2 = gf4_add(gf4_add(gf4_add(x0, x2), gf4_add(s01, s02)),
                      gf4_add(gf4_add(s12, m02), gf4_add(gf4_add(m12, c1), c2)));

  // coordinate order of the result follows the tower basis rather than the input
  always_ff @(posedge clk) begin
    w <= {r1, r0, r2};
  end

endmodule

`default_nettype wire

//--- source/sbox_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "sbox_cfg.svh"

module sbox_lane
  import sbox_ctrl_pkg::*;
(
  input  logic     clk,
  input  sbox_op_e op,
  input  word_t    x,
  output word_t    y
);

  word_t    z;
  word_t    w;
  word_t    p;
  word_t    x_d;
  word_t    mask;
  sbox_op_e op_d;
  logic     t;

  // polynomial basis to tower basis
  function automatic word_t iso_fwd(word_t a);
    word_t b;
    b[0] = a[0] ^ a[2] ^ a[4] ^ a[5];
    b[1] = a[1] ^ a[2] ^ a[4] ^ a[5];
    b[2] = a[0] ^ a[5];
    b[3] = a[4];
    b[4] = a[0] ^ a[1] ^ a[2] ^ a[5];
    b[5] = a[1] ^ a[2] ^ a[3] ^ a[5];
    return b;
  endfunction

  function automatic word_t iso_inv(word_t a);
    word_t b;
    b[0] = a[0] ^ a[1] ^ a[3] ^ a[4];
    b[1] = a[1] ^ a[2] ^ a[4];
    b[2] = a[0] ^ a[1] ^ a[4] ^ a[5];
    b[3] = a[0];
    b[4] = a[3] ^ a[4];
    b[5] = a[2] ^ a[4];
    return b;
  endfunction

  assign z = iso_fwd(x);

  tower_power52 pow_i (
    .clk (clk),
    .z   (z),
    .w   (w)
  );

  // x and op follow the data through stage 1
  always_ff @(posedge clk) begin
    x_d  <= x;
    op_d <= op;
  end

  assign p = iso_inv(w);
  assign t = x_d[2] ^ x_d[4];
  assign mask = (op_d == OP_SBOX) ? {`SBOX_WORD_W{t}} : '0;

  always_ff @(posedge clk) begin
    y <= p ^ mask;
  end

endmodule

`default_nettype wire

//--- source/block_reg.sv
`timescale 1ns/1ns
`default_nettype none

module block_reg
  import sbox_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   load,
  input  logic   capture,
  input  block_t din,
  input  block_t lane_out,
  output block_t q
);

  block_t blk;

  always_ff @(posedge clk) begin
    if (rst) begin
      blk <= '0;
    end else if (load) begin
      blk <= din;
    end else if (capture) begin
      blk <= lane_out;
    end
  end

  // lanes see a round result in its capture cycle, keeping each round at two cycles
  assign q = (capture && !load) ? lane_out : blk;

endmodule

`default_nettype wire

//--- source/sbox_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "sbox_cfg.svh"

module sbox_ctrl
  import sbox_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  sbox_op_e                 op_in,
  input  logic [`SBOX_ROUND_W-1:0] rounds,
  output sbox_op_e                 op,
  output logic                     load,
  output logic                     capture,
  output logic                     busy,
  output logic                     done
);

  ctrl_state_e              state;
  logic                     phase;
  logic [`SBOX_ROUND_W-1:0] rounds_left;

  assign load = (state == ST_IDLE) && start;
  assign busy = (state != ST_IDLE);
  assign done = (state == ST_DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      op          <= OP_SBOX;
      phase       <= 1'b0;
      rounds_left <= '0;
      capture     <= 1'b0;
    end else begin
      capture <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_RUN;
            op    <= op_in;
            phase <= 1'b0;
            // zero rounds runs once
            rounds_left <= (rounds == '0) ? `SBOX_ROUND_W'(1) : rounds;
          end
        end
        ST_RUN: begin
          phase <= ~phase;
          // second pipeline cycle ends and the results land next cycle
          if (phase) begin
            capture     <= 1'b1;
            rounds_left <= rounds_left - 1'b1;
            if (rounds_left == `SBOX_ROUND_W'(1)) begin
              state <= ST_DONE;
            end
          end
        end
        ST_DONE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/sbox_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "sbox_cfg.svh"

module sbox_unit
  import sbox_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  sbox_op_e                 op,
  input  logic [`SBOX_ROUND_W-1:0] rounds,
  input  block_t                   din,
  output block_t                   dout,
  output logic                     busy,
  output logic                     done
);

  sbox_op_e op_q;
  logic     load;
  logic     capture;
  block_t   lane_out;

  sbox_ctrl ctrl_i (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .op_in   (op),
    .rounds  (rounds),
    .op      (op_q),
    .load    (load),
    .capture (capture),
    .busy    (busy),
    .done    (done)
  );

  block_reg blk_i (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .capture  (capture),
    .din      (din),
    .lane_out (lane_out),
    .q        (dout)
  );

  genvar i;
  generate
    for (i = 0; i < `SBOX_LANES; i++) begin : g_lane
      sbox_lane lane_i (
        .clk (clk),
        .op  (op_q),
        .x   (dout[i]),
        .y   (lane_out[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // free running with the first rising edge at half a period
  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- tests/sbox_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sbox_cfg.svh"

module sbox_unit_tb
  import sbox_ctrl_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int MAX_ROUNDS = 15;
  localparam int N_EXH = 16;
  localparam int N_POW = 8;
  localparam int N_MULTI = 12;
  localparam int BUSY_ROUNDS = 5;
  // worst case of 2R+1 cycles per run plus a margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + (N_EXH + N_POW + 2) * 3
                                  + N_MULTI * (2 * MAX_ROUNDS + 1)
                                  + (2 * BUSY_ROUNDS + 1) + 200;

  // bit i of a mapped word is the parity of row i and the input
  localparam logic [5:0][5:0] FWD_ROWS = {6'h2E, 6'h27, 6'h10, 6'h21, 6'h36, 6'h35};
  localparam logic [5:0][5:0] INV_ROWS = {6'h14, 6'h18, 6'h01, 6'h33, 6'h16, 6'h1B};

  logic                     clk;
  logic                     rst;
  logic                     start;
  sbox_op_e                 op;
  logic [`SBOX_ROUND_W-1:0] rounds;
  block_t                   din;
  block_t                   dout;
  logic                     busy;
  logic                     done;

  word_t power_table [64];
  word_t sbox_table [64];
  int    mismatch_count = 0;
  int    failure_count = 0;
  int    run_cycle = 0;
  int    cycle_count = 0;

  tb_clock clk_gen_i (
    .clk (clk)
  );

  sbox_unit dut_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .rounds (rounds),
    .din    (din),
    .dout   (dout),
    .busy   (busy),
    .done   (done)
  );

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [1:0] square4(input logic [1:0] a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic logic [1:0] product4(input logic [1:0] a, input logic [1:0] b);
    logic t;
    t = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ t, (a[0] & b[0]) ^ t};
  endfunction

  // nonzero a has a^3 = 1
  function automatic logic [1:0] masked4(input logic [1:0] a, input logic [1:0] b);
    return (a != 2'b00) ? b : 2'b00;
  endfunction

  function automatic word_t map_linear(input logic [5:0][5:0] rows, input word_t a);
    word_t b;
    for (int i = 0; i < 6; i++) begin
      b[i] = ^(rows[i] & a);
    end
    return b;
  endfunction

  function automatic word_t power_ref(input word_t v);
    word_t      z;
    logic [1:0] x0;
    logic [1:0] x1;
    logic [1:0] x2;
    logic [1:0] q0;
    logic [1:0] q1;
    logic [1:0] q2;
    logic [1:0] r0;
    logic [1:0] r1;
    logic [1:0] r2;
    z = map_linear(FWD_ROWS, v);
    x0 = z[1:0];
    x1 = z[3:2];
    x2 = z[5:4];
    q0 = square4(x0);
    q1 = square4(x1);
    q2 = square4(x2);
    r0 = x0 ^ x1 ^ masked4(x1, x0) ^ masked4(x1, x2) ^ masked4(x2, x0)
         ^ product4(q0, q1) ^ product4(q0, q2)
         ^ product4(q0, product4(x1, x2)) ^ product4(q2, product4(x0, x1));
    r1 = x1 ^ x2 ^ masked4(x0, x1) ^ masked4(x2, x0) ^ masked4(x2, x1)
         ^ product4(q0, q1) ^ product4(q1, q2)
         ^ product4(q0, product4(x1, x2)) ^ product4(q1, product4(x0, x2));
    r2 = x0 ^ x2 ^ masked4(x0, x1) ^ masked4(x0, x2) ^ masked4(x1, x2)
         ^ product4(q0, q2) ^ product4(q1, q2)
         ^ product4(q1, product4(x0, x2)) ^ product4(q2, product4(x0, x1));
    return map_linear(INV_ROWS, {r1, r0, r2});
  endfunction

  task automatic build_tables();
    word_t w;
    word_t p;
    for (int v = 0; v < 64; v++) begin
      w = word_t'(v);
      p = power_ref(w);
      power_table[v] = p;
      sbox_table[v] = p ^ {`SBOX_WORD_W{w[2] ^ w[4]}};
    end
  endtask

  function automatic block_t apply_rounds(input sbox_op_e op_v,
                                          input logic [`SBOX_ROUND_W-1:0] r,
                                          input block_t blk);
    block_t b;
    int     eff;
    b = blk;
    eff = (r == 0) ? 1 : int'(r);
    for (int k = 0; k < eff; k++) begin
      for (int i = 0; i < `SBOX_LANES; i++) begin
        b[i] = (op_v == OP_SBOX) ? sbox_table[b[i]] : power_table[b[i]];
      end
    end
    return b;
  endfunction

  function automatic block_t random_block();
    block_t      b;
    logic [31:0] rnd;
    for (int i = 0; i < `SBOX_LANES; i++) begin
      rnd = $urandom;
      b[i] = rnd[5:0];
    end
    return b;
  endfunction

  task automatic compare_block(input string name, input block_t expected, input block_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
      mismatch_count++;
    end
  endtask

  // advances one cycle to the falling edge where inputs change and outputs are sampled
  task automatic step();
    @(negedge clk);
    run_cycle++;
  endtask

  task automatic start_run(input sbox_op_e op_v, input logic [`SBOX_ROUND_W-1:0] r,
                           input block_t blk);
    start = 1'b1;
    op = op_v;
    rounds = r;
    din = blk;
    run_cycle = 0;
    step();
    start = 1'b0;
    // din must only matter in the start cycle
    din = ~blk;
  endtask

  task automatic wait_done(input string name, input int r_eff, output logic seen);
    int limit;
    limit = 2 * r_eff + 1 + 8;
    seen = 1'b0;
    while (done !== 1'b1 && run_cycle < limit) begin
      compare_bit({name, " busy"}, 1'b1, busy);
      step();
    end
    if (done !== 1'b1) begin
      $display("%s: no done pulse within %0d cycles of start", name, limit);
      failure_count++;
    end else begin
      seen = 1'b1;
      compare_count({name, " latency"}, 2 * r_eff + 1, run_cycle);
      compare_bit({name, " busy at done"}, 1'b1, busy);
    end
  endtask

  task automatic run_and_check(input string name, input sbox_op_e op_v,
                               input logic [`SBOX_ROUND_W-1:0] r, input block_t blk,
                               input block_t expected);
    logic seen;
    start_run(op_v, r, blk);
    wait_done(name, (r == 0) ? 1 : int'(r), seen);
    if (seen) begin
      compare_block({name, " dout at done"}, expected, dout);
      step();
      compare_bit({name, " done pulse end"}, 1'b0, done);
      compare_bit({name, " busy after done"}, 1'b0, busy);
      compare_block({name, " dout held"}, expected, dout);
    end
  endtask

  task automatic test_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    compare_bit("reset busy", 1'b0, busy);
    compare_bit("reset done", 1'b0, done);
    compare_block("reset dout", '0, dout);
    step();
    compare_bit("reset busy", 1'b0, busy);
    compare_block("reset dout", '0, dout);
  endtask

  task automatic test_sbox_exhaustive();
    block_t blk;
    for (int b = 0; b < N_EXH; b++) begin
      for (int i = 0; i < `SBOX_LANES; i++) begin
        blk[i] = word_t'(b * `SBOX_LANES + i);
      end
      run_and_check($sformatf("sbox_exhaustive[%0d]", b), OP_SBOX, 1, blk,
                    apply_rounds(OP_SBOX, 1, blk));
    end
  endtask

  task automatic test_power_random();
    block_t blk;
    // zero maps to zero without looking at the table
    run_and_check("power_zero", OP_POWER, 1, '0, '0);
    for (int n = 1; n < N_POW; n++) begin
      blk = random_block();
      run_and_check($sformatf("power_random[%0d]", n), OP_POWER, 1, blk,
                    apply_rounds(OP_POWER, 1, blk));
    end
  endtask

  task automatic test_multi_round();
    block_t                   blk;
    sbox_op_e                 op_v;
    logic [`SBOX_ROUND_W-1:0] r;
    logic [31:0]              rnd;
    for (int n = 0; n < N_MULTI; n++) begin
      rnd = $urandom;
      op_v = rnd[0] ? OP_POWER : OP_SBOX;
      rnd = $urandom % MAX_ROUNDS;
      r = `SBOX_ROUND_W'(rnd + 1);
      blk = random_block();
      run_and_check($sformatf("multi_round[%0d] r=%0d", n, r), op_v, r, blk,
                    apply_rounds(op_v, r, blk));
    end
    blk = random_block();
    run_and_check("rounds_zero", OP_SBOX, 0, blk, apply_rounds(OP_SBOX, 1, blk));
  endtask

  task automatic test_start_while_busy();
    block_t blk_a;
    block_t blk_b;
    block_t expected;
    logic   seen;
    blk_a = random_block();
    blk_b = random_block();
    expected = apply_rounds(OP_SBOX, BUSY_ROUNDS, blk_a);
    start_run(OP_SBOX, BUSY_ROUNDS, blk_a);
    start = 1'b1;
    op = OP_POWER;
    rounds = 1;
    din = blk_b;
    step();
    start = 1'b0;
    wait_done("busy_start", BUSY_ROUNDS, seen);
    if (seen) begin
      compare_block("busy_start dout at done", expected, dout);
      // a start in the done cycle is ignored as well
      start = 1'b1;
      step();
      start = 1'b0;
      repeat (3) begin
        compare_bit("busy_start done low", 1'b0, done);
        compare_bit("busy_start busy low", 1'b0, busy);
        compare_block("busy_start dout stable", expected, dout);
        step();
      end
    end
    run_and_check("busy_start next", OP_POWER, 1, blk_b, apply_rounds(OP_POWER, 1, blk_b));
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    op = OP_SBOX;
    rounds = '0;
    din = '0;
    void'($urandom(32'h3930));
    build_tables();

    test_reset();
    test_sbox_exhaustive();
    test_power_random();
    test_multi_round();
    test_start_while_busy();

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
source/sbox_ctrl_pkg.sv
source/gf_tower_pkg.sv
source/tower_power52.sv
source/sbox_lane.sv
source/block_reg.sv
source/sbox_ctrl.sv
source/sbox_unit.sv
tests/tb_clock.sv
tests/sbox_unit_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, then run and look for the pass message in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal -f filelist.f --top-module sbox_unit_tb \
       -o sbox_sim \
  && ./obj_dir/sbox_sim | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
